// File: Bender.yml
package:
  name: clint

sources:
  # Package first, then the blocks, then the top level
  - hw/clint_pkg.sv
  - hw/clint_axil_read.sv
  - hw/clint_axil_write.sv
  - hw/clint_regs.sv
  - hw/clint_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clint.sv

// File: all.f
+incdir+include
hw/clint_pkg.sv
hw/clint_axil_read.sv
hw/clint_axil_write.sv
hw/clint_regs.sv
hw/clint_top.sv
testbench/tb_clint.sv

// File: hw/clint_axil_read.sv
`timescale 1ns/1ps

module clint_axil_read (
    input  logic                clock,
    input  logic                reset,
    input  clint_pkg::axil_ar_t ar,
    input  logic                arvalid,
    output logic                arready,
    output clint_pkg::axil_r_t  r,
    output logic                rvalid,
    input  logic                rready,
    output clint_pkg::rd_req_t  rd_req,
    input  clint_pkg::rd_rsp_t  rd_rsp
);

    clint_pkg::rd_state_t state;
    logic                 ar_fire;
    logic                 r_fire;

    // Only one read in flight so AR opens only when idle
    assign arready = (state == clint_pkg::RD_IDLE);
    assign rvalid  = (state == clint_pkg::RD_RESP);
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Address goes to the register block only on the handshake cycle
    // prot is not used
    always_comb begin
        rd_req.valid = ar_fire;
        rd_req.addr  = ar.addr;
    end

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= clint_pkg::RD_IDLE;
        end else begin
            case (state)
                clint_pkg::RD_IDLE: begin
                    if (ar_fire) begin
                        state <= clint_pkg::RD_RESP;
                    end
                end
                clint_pkg::RD_RESP: begin
                    // Back to idle once the master takes R
                    if (r_fire) begin
                        state <= clint_pkg::RD_IDLE;
                    end
                end
                default: state <= clint_pkg::RD_IDLE;
            endcase
        end
    end

    // R beat sampled from the register block on the AR edge
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            r.data <= rd_rsp.data;
            r.resp <= rd_rsp.resp;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Held R beat may not change under back-pressure
    assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(r));

    // Accepted AR leads to a waiting response with AR closed
    assert property (@(posedge clock) disable iff (reset)
        ar_fire |=> rvalid && !arready);

endmodule

// File: hw/clint_axil_write.sv
`timescale 1ns/1ps

module clint_axil_write (
    input  logic                clock,
    input  logic                reset,
    input  clint_pkg::axil_aw_t aw,
    input  logic                awvalid,
    output logic                awready,
    input  clint_pkg::axil_w_t  w,
    input  logic                wvalid,
    output logic                wready,
    output clint_pkg::axil_b_t  b,
    output logic                bvalid,
    input  logic                bready,
    output clint_pkg::wr_req_t  wr_req,
    input  clint_pkg::wr_rsp_t  wr_rsp
);

    clint_pkg::wr_state_t  state;
    logic                  aw_held;
    logic                  w_held;
    clint_pkg::axil_addr_t aw_addr_q;
    clint_pkg::axil_w_t    w_q;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  aw_have;
    logic                  w_have;
    logic                  issue;

    // Each ready drops once its own beat is captured
    assign awready = (state == clint_pkg::WR_COLLECT) && !aw_held;
    assign wready  = (state == clint_pkg::WR_COLLECT) && !w_held;
    assign bvalid  = (state == clint_pkg::WR_RESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // Beat present either from the capture register or the bus this cycle
    assign aw_have = aw_held || aw_fire;
    assign w_have  = w_held || w_fire;
    assign issue   = (state == clint_pkg::WR_COLLECT) && aw_have && w_have;

    // Bypass the capture registers when a beat arrives in the issue cycle
    always_comb begin
        wr_req.valid = issue;
        wr_req.addr  = aw_held ? aw_addr_q : aw.addr;
        wr_req.data  = w_held ? w_q.data : w.data;
        wr_req.strb  = w_held ? w_q.strb : w.strb;
    end

    // ------------------------------
    // FSM and capture flags
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= clint_pkg::WR_COLLECT;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            case (state)
                clint_pkg::WR_COLLECT: begin
                    if (issue) begin
                        state   <= clint_pkg::WR_RESP;
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                    end else begin
                        // Only one side so far, wait for the other
                        if (aw_fire) begin
                            aw_held <= 1'b1;
                        end
                        if (w_fire) begin
                            w_held <= 1'b1;
                        end
                    end
                end
                clint_pkg::WR_RESP: begin
                    if (bready) begin
                        state <= clint_pkg::WR_COLLECT;
                    end
                end
                default: state <= clint_pkg::WR_COLLECT;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            aw_addr_q <= aw.addr;
        end
        if (w_fire) begin
            w_q <= w;
        end
        // B beat from the register block on the write edge
        if (issue) begin
            b.resp <= wr_rsp.resp;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Register block must see each write exactly once
    assert property (@(posedge clock) disable iff (reset)
        wr_req.valid |=> !wr_req.valid);

    // Held B beat stays put until accepted
    assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(b));

endmodule

// File: hw/clint_pkg.sv
package clint_pkg;

    // ------------------------------
    // Bus and timer widths
    // ------------------------------
    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;
    // Shared by mtime and mtimecmp
    typedef logic [63:0] mtime_t;

    // Channel engine states
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;
    typedef enum logic {WR_COLLECT, WR_RESP} wr_state_t;

    // ------------------------------
    // AXI4-Lite payloads
    // ------------------------------
    typedef struct packed {
        axil_addr_t addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_t resp;
    } axil_b_t;

    typedef struct packed {
        axil_addr_t addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    // ------------------------------
    // Engine to register block
    // ------------------------------
    typedef struct packed {
        logic       valid;
        axil_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } rd_rsp_t;

    typedef struct packed {
        logic       valid;
        axil_addr_t addr;
        axil_data_t data;
        axil_strb_t strb;
    } wr_req_t;

    typedef struct packed {
        axil_resp_t resp;
    } wr_rsp_t;

    // Fixed platform map
    localparam axil_addr_t CLINT_BASE      = 32'h0200_0000;
    localparam axil_addr_t MTIME_LO_OFS    = 32'h0000_0000;
    localparam axil_addr_t MTIME_HI_OFS    = 32'h0000_0004;
    localparam axil_addr_t MTIMECMP_LO_OFS = 32'h0000_0008;
    localparam axil_addr_t MTIMECMP_HI_OFS = 32'h0000_000C;
    localparam axil_addr_t MSIP_OFS        = 32'h0000_0010;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

    // Compare value that mtime never reaches in practice
    localparam mtime_t MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage

// File: hw/clint_regs.sv
`timescale 1ns/1ps

module clint_regs (
    input  logic               clock,
    input  logic               reset,
    input  clint_pkg::rd_req_t rd_req,
    output clint_pkg::rd_rsp_t rd_rsp,
    input  clint_pkg::wr_req_t wr_req,
    output clint_pkg::wr_rsp_t wr_rsp,
    output logic               timer_irq,
    output logic               soft_irq
);

    clint_pkg::mtime_t     mtime;
    clint_pkg::mtime_t     mtimecmp;
    logic                  msip;
    clint_pkg::axil_data_t mtime_lo_inc;
    logic                  mtime_carry;

    // Read side hits
    logic rd_mtime_lo;
    logic rd_mtime_hi;
    logic rd_cmp_lo;
    logic rd_cmp_hi;
    logic rd_msip;

    // Write side hits, already qualified by valid
    logic wr_mtime_lo;
    logic wr_mtime_hi;
    logic wr_cmp_lo;
    logic wr_cmp_hi;
    logic wr_msip;

    // Exact match against base plus offset
    function automatic logic hit(input clint_pkg::axil_addr_t addr,
                                 input clint_pkg::axil_addr_t ofs);
        return addr == (clint_pkg::CLINT_BASE + ofs);
    endfunction

    // Byte lane merge of new data over the old word
    function automatic clint_pkg::axil_data_t merge(input clint_pkg::axil_data_t old_word,
                                                    input clint_pkg::axil_data_t new_word,
                                                    input clint_pkg::axil_strb_t strb);
        clint_pkg::axil_data_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ------------------------------
    // Decode
    // ------------------------------
    assign rd_mtime_lo = hit(rd_req.addr, clint_pkg::MTIME_LO_OFS);
    assign rd_mtime_hi = hit(rd_req.addr, clint_pkg::MTIME_HI_OFS);
    assign rd_cmp_lo   = hit(rd_req.addr, clint_pkg::MTIMECMP_LO_OFS);
    assign rd_cmp_hi   = hit(rd_req.addr, clint_pkg::MTIMECMP_HI_OFS);
    assign rd_msip     = hit(rd_req.addr, clint_pkg::MSIP_OFS);

    assign wr_mtime_lo = wr_req.valid && hit(wr_req.addr, clint_pkg::MTIME_LO_OFS);
    assign wr_mtime_hi = wr_req.valid && hit(wr_req.addr, clint_pkg::MTIME_HI_OFS);
    assign wr_cmp_lo   = wr_req.valid && hit(wr_req.addr, clint_pkg::MTIMECMP_LO_OFS);
    assign wr_cmp_hi   = wr_req.valid && hit(wr_req.addr, clint_pkg::MTIMECMP_HI_OFS);
    assign wr_msip     = wr_req.valid && hit(wr_req.addr, clint_pkg::MSIP_OFS);

    // Read mux, sees state from before any write on this edge
    always_comb begin
        rd_rsp.data = '0;
        rd_rsp.resp = clint_pkg::RESP_OKAY;
        if (rd_req.valid) begin
            if (rd_mtime_lo) begin
                rd_rsp.data = mtime[31:0];
            end else if (rd_mtime_hi) begin
                rd_rsp.data = mtime[63:32];
            end else if (rd_cmp_lo) begin
                rd_rsp.data = mtimecmp[31:0];
            end else if (rd_cmp_hi) begin
                rd_rsp.data = mtimecmp[63:32];
            end else if (rd_msip) begin
                rd_rsp.data = {31'd0, msip};
            end else begin
                rd_rsp.resp = clint_pkg::RESP_SLVERR;
            end
        end
    end

    // Unmapped write is dropped and answered with SLVERR
    always_comb begin
        wr_rsp.resp = clint_pkg::RESP_OKAY;
        if (wr_req.valid && !(wr_mtime_lo || wr_mtime_hi || wr_cmp_lo || wr_cmp_hi || wr_msip)) begin
            wr_rsp.resp = clint_pkg::RESP_SLVERR;
        end
    end

    // ------------------------------
    // Timer and registers
    // ------------------------------
    // Low word increment, carry feeds the high word
    assign {mtime_carry, mtime_lo_inc} = {1'b0, mtime[31:0]} + 33'd1;

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= clint_pkg::MTIMECMP_RESET;
            msip     <= 1'b0;
        end else begin
            // Written word replaces the count, the other keeps counting
            mtime[31:0] <= wr_mtime_lo ? merge(mtime[31:0], wr_req.data, wr_req.strb)
                                       : mtime_lo_inc;
            mtime[63:32] <= wr_mtime_hi ? merge(mtime[63:32], wr_req.data, wr_req.strb)
                                        : mtime[63:32] + {31'd0, mtime_carry};
            if (wr_cmp_lo) begin
                mtimecmp[31:0] <= merge(mtimecmp[31:0], wr_req.data, wr_req.strb);
            end
            if (wr_cmp_hi) begin
                mtimecmp[63:32] <= merge(mtimecmp[63:32], wr_req.data, wr_req.strb);
            end
            // msip lives in lane 0 only
            if (wr_msip && wr_req.strb[0]) begin
                msip <= wr_req.data[0];
            end
        end
    end

    // Registered interrupts, unsigned compare
    always_ff @(posedge clock) begin
        if (reset) begin
            timer_irq <= 1'b0;
            soft_irq  <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
            soft_irq  <= msip;
        end
    end

    // Parked compare value keeps the timer quiet on the next cycle
    assert property (@(posedge clock) disable iff (reset)
        mtimecmp == clint_pkg::MTIMECMP_RESET && mtime != '1 |=> !timer_irq);

endmodule

// File: hw/clint_top.sv
`timescale 1ns/1ps

module clint_top (
    input  logic                clock,
    input  logic                reset,
    // AXI4-Lite write channels
    input  clint_pkg::axil_aw_t aw,
    input  logic                awvalid,
    output logic                awready,
    input  clint_pkg::axil_w_t  w,
    input  logic                wvalid,
    output logic                wready,
    output clint_pkg::axil_b_t  b,
    output logic                bvalid,
    input  logic                bready,
    // AXI4-Lite read channels
    input  clint_pkg::axil_ar_t ar,
    input  logic                arvalid,
    output logic                arready,
    output clint_pkg::axil_r_t  r,
    output logic                rvalid,
    input  logic                rready,
    // Interrupts to the hart
    output logic                timer_irq,
    output logic                soft_irq
);

    // Engine to register block
    clint_pkg::rd_req_t rd_req;
    clint_pkg::rd_rsp_t rd_rsp;
    clint_pkg::wr_req_t wr_req;
    clint_pkg::wr_rsp_t wr_rsp;

    // ------------------------------
    // Channel engines
    // ------------------------------
    clint_axil_read clint_axil_read_inst (
        .clock   (clock),
        .reset   (reset),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp)
    );

    clint_axil_write clint_axil_write_inst (
        .clock   (clock),
        .reset   (reset),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp)
    );

    // Register block owns all state
    clint_regs clint_regs_inst (
        .clock     (clock),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .wr_req    (wr_req),
        .wr_rsp    (wr_rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule

// File: include/clint_tb_tasks.svh
`ifndef CLINT_TB_TASKS_SVH
`define CLINT_TB_TASKS_SVH

// ------------------------------
// Typed compare tasks
// ------------------------------
task automatic check_data(input string name, input clint_pkg::axil_data_t expected,
                          input clint_pkg::axil_data_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h got %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_resp(input string name, input clint_pkg::axil_resp_t expected,
                          input clint_pkg::axil_resp_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h got %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h got %h", name, expected, actual);
        errors++;
    end
endtask

// Inclusive range for counts that may drift by a few cycles
task automatic check_window(input string name, input clint_pkg::axil_data_t low,
                            input clint_pkg::axil_data_t high,
                            input clint_pkg::axil_data_t actual);
    if (actual < low || actual > high) begin
        $display("ERR %s expected %h..%h got %h", name, low, high, actual);
        errors++;
    end
endtask

// ------------------------------
// AXI4-Lite master
// ------------------------------
// Step to just past the next rising edge
task automatic tick();
    @(posedge clock);
    #1;
endtask

task automatic axil_read(input clint_pkg::axil_addr_t addr,
                         output clint_pkg::axil_data_t data,
                         output clint_pkg::axil_resp_t resp);
    logic accepted;
    accepted = 1'b0;
    ar.addr  = addr;
    ar.prot  = 3'd0;
    arvalid  = 1'b1;
    // Ready seen now means the beat goes on the coming edge
    while (!accepted) begin
        accepted = arready;
        tick();
    end
    arvalid  = 1'b0;
    ar_cycle = cycle;
    // Back-pressure on R
    repeat (rready_delay) tick();
    rready = 1'b1;
    while (!rvalid) begin
        tick();
    end
    data = r.data;
    resp = r.resp;
    tick();
    rready = 1'b0;
    // Still valid here would be a second R beat
    check_bit("rvalid after R", 1'b0, rvalid);
endtask

// write_order 0 sends both at once, 1 sends AW first and 2 sends W first
task automatic axil_write(input clint_pkg::axil_addr_t addr, input clint_pkg::axil_data_t data,
                          input clint_pkg::axil_strb_t strb,
                          output clint_pkg::axil_resp_t resp);
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;
    aw_done = 1'b0;
    w_done  = 1'b0;
    aw.addr = addr;
    aw.prot = 3'd0;
    w.data  = data;
    w.strb  = strb;
    awvalid = (write_order != 2);
    wvalid  = (write_order != 1);
    while (!(aw_done && w_done)) begin
        aw_fire = awvalid && awready;
        w_fire  = wvalid && wready;
        tick();
        // A taken payload is scrambled so only the captured copy is right
        if (aw_fire) begin
            aw_done = 1'b1;
            awvalid = 1'b0;
            aw.addr = ~addr;
        end
        if (w_fire) begin
            w_done = 1'b1;
            wvalid = 1'b0;
            w.data = ~data;
            w.strb = ~strb;
        end
        // Trailing channel opens once the leading one is taken
        if (aw_done && !w_done && !wvalid) begin
            wvalid = 1'b1;
        end
        if (w_done && !aw_done && !awvalid) begin
            awvalid = 1'b1;
        end
    end
    repeat (bready_delay) tick();
    bready = 1'b1;
    while (!bvalid) begin
        tick();
    end
    resp = b.resp;
    tick();
    bready = 1'b0;
    check_bit("bvalid after B", 1'b0, bvalid);
endtask

`endif

// File: testbench/tb_clint.sv
`timescale 1ns/1ps

module tb_clint;

    logic                clock;
    logic                reset;
    clint_pkg::axil_aw_t aw;
    logic                awvalid;
    logic                awready;
    clint_pkg::axil_w_t  w;
    logic                wvalid;
    logic                wready;
    clint_pkg::axil_b_t  b;
    logic                bvalid;
    logic                bready;
    clint_pkg::axil_ar_t ar;
    logic                arvalid;
    logic                arready;
    clint_pkg::axil_r_t  r;
    logic                rvalid;
    logic                rready;
    logic                timer_irq;
    logic                soft_irq;

    // Run bookkeeping
    int     cycle;
    int     ar_cycle;
    int     errors;
    int     test_count;
    int     failed_tests;
    int     rready_delay;
    int     bready_delay;
    int     write_order;
    integer seed;

    `include "clint_tb_tasks.svh"

    clint_top clint_top_inst (
        .clock     (clock),
        .reset     (reset),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Tests take well under 1000 cycles, so 4000 means a stuck handshake
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= 4000) begin
            $display("Timeout: run still going after %0d cycles", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic clint_pkg::axil_addr_t reg_addr(input clint_pkg::axil_addr_t ofs);
        return clint_pkg::CLINT_BASE + ofs;
    endfunction

    // Strobed lanes take the new byte
    function automatic clint_pkg::axil_data_t lane_merge(input clint_pkg::axil_data_t old_word,
                                                         input clint_pkg::axil_data_t new_word,
                                                         input clint_pkg::axil_strb_t strb);
        clint_pkg::axil_data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    // Two mtime reads, the gap must track the AR edges
    task automatic check_mtime_step(input string name);
        clint_pkg::axil_data_t v1;
        clint_pkg::axil_data_t v2;
        clint_pkg::axil_resp_t resp;
        int                    c1;
        axil_read(reg_addr(clint_pkg::MTIME_LO_OFS), v1, resp);
        check_resp("mtime_lo resp", clint_pkg::RESP_OKAY, resp);
        c1 = ar_cycle;
        repeat (3 + {$random(seed)} % 20) tick();
        axil_read(reg_addr(clint_pkg::MTIME_LO_OFS), v2, resp);
        check_resp("mtime_lo resp", clint_pkg::RESP_OKAY, resp);
        check_window(name, ar_cycle - c1, ar_cycle - c1 + 4, v2 - v1);
    endtask

    task automatic set_msip_and_check(input clint_pkg::axil_data_t data,
                                      input clint_pkg::axil_strb_t strb, input logic expected);
        clint_pkg::axil_data_t rd;
        clint_pkg::axil_resp_t resp;
        axil_write(reg_addr(clint_pkg::MSIP_OFS), data, strb, resp);
        check_resp("msip write resp", clint_pkg::RESP_OKAY, resp);
        tick();
        check_bit("soft_irq", expected, soft_irq);
        axil_read(reg_addr(clint_pkg::MSIP_OFS), rd, resp);
        check_data("msip", {31'd0, expected}, rd);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_counter_runs();
        clint_pkg::axil_data_t hi;
        clint_pkg::axil_resp_t resp;
        int                    start;
        start = errors;
        // Reset state of the port and interrupts
        check_bit("arready", 1'b1, arready);
        check_bit("awready", 1'b1, awready);
        check_bit("wready", 1'b1, wready);
        check_bit("rvalid", 1'b0, rvalid);
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("timer_irq", 1'b0, timer_irq);
        check_bit("soft_irq", 1'b0, soft_irq);
        check_mtime_step("mtime_lo delta");
        axil_read(reg_addr(clint_pkg::MTIME_HI_OFS), hi, resp);
        check_resp("mtime_hi resp", clint_pkg::RESP_OKAY, resp);
        check_data("mtime_hi", 32'd0, hi);
        report_test("counter_runs", start);
    endtask

    task automatic test_timer_write();
        clint_pkg::mtime_t     exp_cmp;
        clint_pkg::axil_data_t data;
        clint_pkg::axil_strb_t strb;
        clint_pkg::axil_data_t rd;
        clint_pkg::axil_resp_t resp;
        int                    start;
        start = errors;
        // Low word 16 counts short of wrapping
        axil_write(reg_addr(clint_pkg::MTIME_LO_OFS), 32'hFFFF_FFF0, 4'hF, resp);
        check_resp("mtime_lo write resp", clint_pkg::RESP_OKAY, resp);
        axil_write(reg_addr(clint_pkg::MTIME_HI_OFS), 32'd0, 4'hF, resp);
        check_resp("mtime_hi write resp", clint_pkg::RESP_OKAY, resp);
        repeat (40) tick();
        axil_read(reg_addr(clint_pkg::MTIME_HI_OFS), rd, resp);
        check_data("mtime_hi after carry", 32'd1, rd);
        exp_cmp = clint_pkg::MTIMECMP_RESET;
        for (int i = 0; i < 4; i++) begin
            data = $random(seed);
            strb = $random(seed);
            if (i % 2 == 0) begin
                axil_write(reg_addr(clint_pkg::MTIMECMP_LO_OFS), data, strb, resp);
                exp_cmp[31:0] = lane_merge(exp_cmp[31:0], data, strb);
                axil_read(reg_addr(clint_pkg::MTIMECMP_LO_OFS), rd, resp);
                check_data("mtimecmp_lo", exp_cmp[31:0], rd);
            end else begin
                axil_write(reg_addr(clint_pkg::MTIMECMP_HI_OFS), data, strb, resp);
                exp_cmp[63:32] = lane_merge(exp_cmp[63:32], data, strb);
                axil_read(reg_addr(clint_pkg::MTIMECMP_HI_OFS), rd, resp);
                check_data("mtimecmp_hi", exp_cmp[63:32], rd);
            end
            check_resp("mtimecmp resp", clint_pkg::RESP_OKAY, resp);
        end
        report_test("timer_write", start);
    endtask

    task automatic test_timer_irq();
        clint_pkg::axil_data_t lo;
        clint_pkg::axil_data_t hi;
        clint_pkg::mtime_t     cmp;
        clint_pkg::axil_resp_t resp;
        int                    start;
        int                    c1;
        start = errors;
        // Park the compare value first
        axil_write(reg_addr(clint_pkg::MTIMECMP_HI_OFS), '1, 4'hF, resp);
        axil_write(reg_addr(clint_pkg::MTIMECMP_LO_OFS), '1, 4'hF, resp);
        tick();
        tick();
        check_bit("timer_irq parked", 1'b0, timer_irq);
        axil_read(reg_addr(clint_pkg::MTIME_LO_OFS), lo, resp);
        c1 = ar_cycle;
        axil_read(reg_addr(clint_pkg::MTIME_HI_OFS), hi, resp);
        cmp = {hi, lo} + 64'd50;
        // Low word first, the high word stays parked until the second write
        axil_write(reg_addr(clint_pkg::MTIMECMP_LO_OFS), cmp[31:0], 4'hF, resp);
        axil_write(reg_addr(clint_pkg::MTIMECMP_HI_OFS), cmp[63:32], 4'hF, resp);
        while (!timer_irq && (cycle - c1) < 70) begin
            tick();
        end
        check_window("timer_irq delay", 32'd50, 32'd60, cycle - c1);
        axil_write(reg_addr(clint_pkg::MTIMECMP_HI_OFS), '1, 4'hF, resp);
        tick();
        check_bit("timer_irq after park", 1'b0, timer_irq);
        report_test("timer_irq", start);
    endtask

    task automatic test_soft_irq();
        int start;
        start = errors;
        set_msip_and_check(32'd1, 4'hF, 1'b1);
        set_msip_and_check(32'd0, 4'hF, 1'b0);
        // Lane 0 masked off
        set_msip_and_check(32'd1, 4'hE, 1'b0);
        report_test("soft_irq", start);
    endtask

    task automatic test_decode_errors();
        clint_pkg::axil_addr_t bad [3];
        clint_pkg::axil_data_t rd;
        clint_pkg::axil_resp_t resp;
        int                    start;
        start  = errors;
        bad[0] = reg_addr(32'h14);
        bad[1] = reg_addr(32'h100);
        // Same low bits as msip, outside the base
        bad[2] = 32'h0300_0010;
        set_msip_and_check(32'd1, 4'hF, 1'b1);
        for (int i = 0; i < 3; i++) begin
            axil_write(bad[i], 32'd0, 4'hF, resp);
            check_resp("unmapped write resp", clint_pkg::RESP_SLVERR, resp);
            axil_read(bad[i], rd, resp);
            check_resp("unmapped read resp", clint_pkg::RESP_SLVERR, resp);
            check_data("unmapped read data", 32'd0, rd);
        end
        axil_read(reg_addr(clint_pkg::MSIP_OFS), rd, resp);
        check_data("msip after errors", 32'd1, rd);
        set_msip_and_check(32'd0, 4'hF, 1'b0);
        report_test("decode_errors", start);
    endtask

    task automatic test_handshakes();
        clint_pkg::axil_data_t data;
        clint_pkg::axil_data_t rd;
        clint_pkg::axil_resp_t resp;
        int                    start;
        start = errors;
        for (int order = 0; order < 3; order++) begin
            write_order  = order;
            rready_delay = {$random(seed)} % 8;
            bready_delay = {$random(seed)} % 8;
            data         = $random(seed);
            axil_write(reg_addr(clint_pkg::MTIMECMP_LO_OFS), data, 4'hF, resp);
            check_resp("mtimecmp_lo write resp", clint_pkg::RESP_OKAY, resp);
            axil_read(reg_addr(clint_pkg::MTIMECMP_LO_OFS), rd, resp);
            check_data("mtimecmp_lo", data, rd);
            set_msip_and_check(order % 2, 4'hF, order % 2);
            check_mtime_step("mtime_lo delta held");
        end
        write_order  = 0;
        rready_delay = 0;
        bready_delay = 0;
        report_test("handshakes", start);
    endtask

    initial begin
        seed         = 32'he49e;
        cycle        = 0;
        ar_cycle     = 0;
        errors       = 0;
        test_count   = 0;
        failed_tests = 0;
        rready_delay = 0;
        bready_delay = 0;
        write_order  = 0;
        aw           = '0;
        awvalid      = 1'b0;
        w            = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        ar           = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        reset        = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        test_counter_runs();
        test_timer_write();
        test_timer_irq();
        test_soft_irq();
        test_decode_errors();
        test_handshakes();
        $display("%0d tests, %0d failed, %0d check errors", test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
